// File: Makefile
# Verilator flow for the host link driver testbench

TOP := qa_driver_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

// File: dv/qa_driver_chk.sv
// Host link protocol checks

module qa_driver_chk
(
    input  logic    vl_clk_LPdomain_32ui,
    input  logic    rst_n,
    input  logic    tx0_almostfull,
    input  logic    tx1_almostfull,
    input  logic    tx0_rdvalid,
    input  logic    tx1_wrvalid,
    input  logic    rx0_rdvalid,
    input  logic    rx_fifo_rdy,
    input  logic    tx_fifo_rdy
);

    logic   reset_seen = 1'b0;  // Set once the flops have taken reset
    int     in_flight;          // Reads sent to the host and not yet answered

    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            reset_seen <= 1'b1;
            in_flight  <= 0;
        end
        else
            in_flight <= in_flight + int'(tx0_rdvalid) - int'(rx0_rdvalid);
    end

    // ------------------------------------------------------------
    // Back-pressure and reorder depth
    // ------------------------------------------------------------
    assert property (@(posedge vl_clk_LPdomain_32ui) disable iff (!rst_n)
        tx0_almostfull |=> !tx0_rdvalid)
        else $error("Read request one cycle after tx0 almost-full");

    assert property (@(posedge vl_clk_LPdomain_32ui) disable iff (!rst_n)
        tx1_almostfull |=> !tx1_wrvalid)
        else $error("Write request one cycle after tx1 almost-full");

    assert property (@(posedge vl_clk_LPdomain_32ui) disable iff (!rst_n)
        in_flight <= 4)
        else $error("More than four reads in flight");

    // Quiet outputs while reset is held
    assert property (@(posedge vl_clk_LPdomain_32ui)
        (!rst_n && reset_seen) |-> !(tx0_rdvalid || tx1_wrvalid || rx_fifo_rdy || tx_fifo_rdy))
        else $error("Output active during reset");

endmodule

bind qa_driver qa_driver_chk chk_inst
(
    .vl_clk_LPdomain_32ui(vl_clk_LPdomain_32ui), .rst_n(rst_n),
    .tx0_almostfull(tx0_almostfull), .tx1_almostfull(tx1_almostfull),
    .tx0_rdvalid(tx0_rdvalid), .tx1_wrvalid(tx1_wrvalid), .rx0_rdvalid(rx0_rdvalid),
    .rx_fifo_rdy(rx_fifo_rdy), .tx_fifo_rdy(tx_fifo_rdy)
);

// File: dv/qa_driver_golden.txt
// Words 0-2: read base, write base, status address. Words 3-22: lines the client receives
// (ring lines 0-15, then 0-3 again). Words 23-42: client transmit words. Word 43: final status
0000000000001000 0000000000002000 0000000000003000
// Read ring
0123456789abcdef 1032547698badcfe 2301674589efcdab 3210765498fedcba
456789abcdef0123 56789abcdef01234 6789abcdef012345 789abcdef0123456
89abcdef01234567 9abcdef012345678 abcdef0123456789 bcdef0123456789a
cdef0123456789ab def0123456789abc ef0123456789abcd f0123456789abcde
0123456789abcdef 1032547698badcfe 2301674589efcdab 3210765498fedcba
// Client transmit words
5a5a000000000101 5a5a000000000202 5a5a000000000303 5a5a000000000404
c3c3000000001105 c3c3000000002206 c3c3000000003307 c3c3000000004408
7e7e00000000a009 7e7e00000000b00a 7e7e00000000c00b 7e7e00000000d00c
0f0f00000001000d 0f0f00000002000e 0f0f00000003000f 0f0f000000040010
e1e1000000100011 e1e1000000200012 e1e1000000300013 e1e1000000400014
// Final consumed count
0000000000000014

// File: dv/qa_driver_tb.sv
// Host link driver testbench

module qa_driver_tb;

    localparam int DATA_WIDTH = 64;
    localparam int N_LINES    = 20;     // Lines consumed and words written
    localparam int RING_SIZE  = 16;
    localparam int SLOT_COUNT = 4;      // Reorder slots in the reader
    localparam int TIMEOUT    = 2000;   // Cycle limit of each wait loop

    logic                   vl_clk_LPdomain_32ui;
    logic                   rst_n;
    qa_drv_pkg::t_rx_hdr    rx0_hdr;
    logic [DATA_WIDTH-1:0]  rx0_data;
    logic                   rx0_rdvalid, rx0_cfgvalid;
    logic                   tx0_almostfull, tx1_almostfull, lp_initdone;
    qa_drv_pkg::t_tx_hdr    tx0_hdr, tx1_hdr;
    logic                   tx0_rdvalid, tx1_wrvalid;
    logic [DATA_WIDTH-1:0]  tx1_data, rx_fifo_data, tx_fifo_data;
    logic                   rx_fifo_rdy, rx_fifo_enable, tx_fifo_rdy, tx_fifo_enable;

    logic [63:0]    golden [0:43];      // CSRs, receive lines, transmit words, final status
    int             seed = 24240;
    int             cycle, rd_count, pop_count, push_count, wr_count;
    int             last_status;        // -1 until the first status write
    int             pend_due[$];        // Host read responses still owed
    int             pend_idx[$];
    logic [11:0]    pend_tag[$];

    qa_driver #(.DATA_WIDTH(DATA_WIDTH), .RING_LOG(4), .SLOT_LOG(2)) uut (.*);

    initial
    begin
        vl_clk_LPdomain_32ui = 1'b0;
        forever #2 vl_clk_LPdomain_32ui = ~vl_clk_LPdomain_32ui;
    end

    // ------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------
    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
        $display("TEST FAIL");
        $fatal(1, "Mismatch");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out at time %0t while waiting for %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "Timeout");
    endtask

    // One cycle with all outputs required low
    task automatic idle_cycle();
        @(negedge vl_clk_LPdomain_32ui);
        assert (!tx0_rdvalid && !tx1_wrvalid && !rx_fifo_rdy && !tx_fifo_rdy)
        else report_mismatch("outputs active before enable",
                             {tx0_rdvalid, tx1_wrvalid, rx_fifo_rdy, tx_fifo_rdy}, 0);
        @(posedge vl_clk_LPdomain_32ui);
        #1;
    endtask

    task automatic write_csr(input logic [11:0] index, input logic [63:0] value);
        rx0_hdr       = '0;
        rx0_hdr.mdata = index;          // CSR index rides in the tag field
        rx0_data      = value;
        rx0_cfgvalid  = 1'b1;
        idle_cycle();
        rx0_cfgvalid  = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Monitors sampled at the falling edge
    // ------------------------------------------------------------
    task automatic check_write();
        if (tx1_hdr.addr == golden[2][31:0])
        begin
            assert (tx1_hdr.req_type == qa_drv_pkg::REQ_WR_LINE)
            else report_mismatch("status write type", tx1_hdr.req_type, qa_drv_pkg::REQ_WR_LINE);
            assert (tx1_hdr.mdata == 12'h000)
            else report_mismatch("status write tag", tx1_hdr.mdata, 0);
            assert (int'(tx1_data[31:0]) >= last_status)
            else report_mismatch("status value decreased", tx1_data, last_status);
            last_status = int'(tx1_data[31:0]);
        end
        else
        begin
            assert (wr_count < push_count)
            else report_mismatch("frame write without a client word", wr_count, push_count);
            assert (tx1_hdr.req_type == qa_drv_pkg::REQ_WR_LINE)
            else report_mismatch("frame write type", tx1_hdr.req_type, qa_drv_pkg::REQ_WR_LINE);
            assert (tx1_hdr.addr == golden[1][31:0] + 32'(wr_count % RING_SIZE))
            else report_mismatch("frame write address", tx1_hdr.addr,
                                 golden[1][31:0] + 32'(wr_count % RING_SIZE));
            assert (tx1_hdr.mdata == 12'(wr_count % RING_SIZE))     // Tag is the ring index
            else report_mismatch("frame write tag", tx1_hdr.mdata, wr_count % RING_SIZE);
            assert (tx1_data == golden[23 + wr_count])
            else report_mismatch("frame write data", tx1_data, golden[23 + wr_count]);
            wr_count++;
        end
    endtask

    task automatic sample_outputs();
        if (tx0_rdvalid)
        begin
            assert (tx0_hdr.req_type == qa_drv_pkg::REQ_RD_LINE)
            else report_mismatch("read request type", tx0_hdr.req_type, qa_drv_pkg::REQ_RD_LINE);
            assert (tx0_hdr.addr == golden[0][31:0] + 32'(rd_count % RING_SIZE))
            else report_mismatch("read request address", tx0_hdr.addr,
                                 golden[0][31:0] + 32'(rd_count % RING_SIZE));
            assert (tx0_hdr.mdata == 12'(rd_count % SLOT_COUNT))   // Ring index modulo slots
            else report_mismatch("read request tag", tx0_hdr.mdata, rd_count % SLOT_COUNT);
            pend_due.push_back(cycle + 1 + int'($unsigned($random(seed)) % 6));   // 1 to 6
            pend_idx.push_back(rd_count % RING_SIZE);
            pend_tag.push_back(tx0_hdr.mdata);
            rd_count++;
        end
        if (rx_fifo_enable && rx_fifo_rdy)
        begin
            assert (rx_fifo_data == golden[3 + pop_count])
            else report_mismatch("client receive line", rx_fifo_data, golden[3 + pop_count]);
            pop_count++;
        end
        if (tx_fifo_enable && tx_fifo_rdy)
            push_count++;
        if (tx1_wrvalid)
            check_write();
    endtask

    // ------------------------------------------------------------
    // Stimulus driven just after the rising edge
    // ------------------------------------------------------------
    task automatic drive_inputs();
        int k;
        cycle++;
        tx0_almostfull = ($unsigned($random(seed)) % 4) == 0;
        tx1_almostfull = ($unsigned($random(seed)) % 4) == 0;
        rx_fifo_enable = (pop_count < N_LINES) && (($unsigned($random(seed)) % 3) != 0);
        tx_fifo_enable = (push_count < N_LINES) && (($unsigned($random(seed)) % 2) == 0);
        tx_fifo_data   = golden[23 + push_count];
        rx0_rdvalid    = 1'b0;
        k = 0;
        while (k < pend_due.size() && pend_due[k] > cycle)
            k++;                                // First response whose delay is over
        if (k < pend_due.size())
        begin
            rx0_hdr          = '0;
            rx0_hdr.rsp_type = qa_drv_pkg::RSP_RD_LINE;
            rx0_hdr.mdata    = pend_tag[k];
            rx0_data         = golden[3 + pend_idx[k]];   // Ring line at addr minus base
            rx0_rdvalid      = 1'b1;
            pend_due.delete(k);
            pend_idx.delete(k);
            pend_tag.delete(k);
        end
    endtask

    task automatic run_cycle();
        @(negedge vl_clk_LPdomain_32ui);
        sample_outputs();
        @(posedge vl_clk_LPdomain_32ui);
        #1;
        drive_inputs();
    endtask

    initial
    begin
        int n;
        rst_n = 1'b0;
        rx0_hdr = '0;
        rx0_data = '0;
        rx0_rdvalid = 1'b0;
        rx0_cfgvalid = 1'b0;
        tx0_almostfull = 1'b0;
        tx1_almostfull = 1'b0;
        lp_initdone = 1'b0;
        rx_fifo_enable = 1'b0;
        tx_fifo_data = '0;
        tx_fifo_enable = 1'b0;
        last_status = -1;
        $readmemh("dv/qa_driver_golden.txt", golden);

        @(posedge vl_clk_LPdomain_32ui);
        #1;
        for (n = 0; n < 15; n++)
            idle_cycle();                       // 16 reset edges in all
        rst_n = 1'b1;
        lp_initdone = 1'b1;
        idle_cycle();
        write_csr(qa_drv_pkg::CSR_READ_BASE, golden[0]);
        write_csr(qa_drv_pkg::CSR_WRITE_BASE, golden[1]);
        write_csr(qa_drv_pkg::CSR_STATUS_ADDR, golden[2]);
        write_csr(qa_drv_pkg::CSR_ENABLE, 64'h1);

        // Both data paths run until every line and word has gone through
        for (n = 0; n < TIMEOUT && !(pop_count == N_LINES && wr_count == N_LINES); n++)
            run_cycle();
        if (n == TIMEOUT)
            abort_on_timeout("all receive lines and frame writes");

        for (n = 0; n < TIMEOUT && last_status != int'(golden[43]); n++)
            run_cycle();
        if (n == TIMEOUT)
            abort_on_timeout("the final status write");

        // Quiet period in which no later status write may change the count
        for (n = 0; n < 40; n++)
            run_cycle();
        assert (last_status == int'(golden[43]))
        else report_mismatch("final status", last_status, golden[43]);

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: logic/cci_write_arbiter.sv
// Round-robin arbiter for tx channel 1

module cci_write_arbiter
#(
    parameter int DATA_WIDTH = 64
)
(
    input  logic                    vl_clk_LPdomain_32ui,
    input  logic                    rst_n,
    input  logic                    almostfull,

    input  logic                    req_valid_a,    // Frame writer
    input  qa_drv_pkg::t_tx_hdr     req_hdr_a,
    input  logic [DATA_WIDTH-1:0]   req_data_a,
    input  logic                    req_valid_b,    // Status writer
    input  qa_drv_pkg::t_tx_hdr     req_hdr_b,
    input  logic [DATA_WIDTH-1:0]   req_data_b,

    output logic                    grant_a,
    output logic                    grant_b,
    output qa_drv_pkg::t_tx_hdr     wr_hdr,
    output logic [DATA_WIDTH-1:0]   wr_data,
    output logic                    wr_valid
);

    logic last_b;   // Requester b won the most recent grant

    // On contention the side that did not win last goes first
    assign grant_a  = !almostfull && req_valid_a && (!req_valid_b || last_b);
    assign grant_b  = !almostfull && req_valid_b && (!req_valid_a || !last_b);
    assign wr_valid = grant_a || grant_b;
    assign wr_hdr   = grant_b ? req_hdr_b  : req_hdr_a;
    assign wr_data  = grant_b ? req_data_b : req_data_a;

    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
            last_b <= 1'b0;
        else if (wr_valid)
            last_b <= grant_b;
    end

endmodule

// File: logic/frame_reader.sv
// Ring reader with response reorder slots

module frame_reader
#(
    parameter int DATA_WIDTH = 64,
    parameter int RING_LOG   = 4,
    parameter int SLOT_LOG   = 2
)
(
    input  logic                    vl_clk_LPdomain_32ui,
    input  logic                    rst_n,

    input  logic                    enable,
    input  logic                    lp_initdone,
    input  logic [31:0]             read_base,
    input  logic                    almostfull,      // tx channel 0 back-pressure

    // Read requests toward tx channel 0
    output qa_drv_pkg::t_tx_hdr     rd_req_hdr,
    output logic                    rd_req_valid,

    // Read responses from rx channel 0
    input  logic                    rsp_valid,
    input  logic [11:0]             rsp_tag,
    input  logic [DATA_WIDTH-1:0]   rsp_data,

    // Client receive stream
    output logic [DATA_WIDTH-1:0]   rx_fifo_data,
    output logic                    rx_fifo_rdy,
    input  logic                    rx_fifo_enable,

    output logic [RING_LOG:0]       consumed_count   // Lines popped, wraps
);

    localparam int SLOTS = 1 << SLOT_LOG;
    localparam logic [RING_LOG:0] SLOT_LIMIT = (RING_LOG+1)'(SLOTS);

    logic [RING_LOG:0]      issue_cnt;              // Lines requested, wraps
    logic [RING_LOG:0]      in_use;                 // Slots requested but not popped
    logic [SLOT_LOG-1:0]    head;                   // Next slot due to the client
    logic [SLOT_LOG-1:0]    rsp_slot;
    logic [SLOTS-1:0]       slot_full;
    logic [DATA_WIDTH-1:0]  slot_data [SLOTS];
    logic                   pop;

    // ------------------------------------------------------------
    // Request issue
    // ------------------------------------------------------------
    assign in_use = issue_cnt - consumed_count;     // Modular difference
    assign rd_req_valid = enable && lp_initdone && !almostfull && (in_use < SLOT_LIMIT);

    always_comb
    begin
        rd_req_hdr          = '0;
        rd_req_hdr.req_type = qa_drv_pkg::REQ_RD_LINE;
        rd_req_hdr.addr     = read_base + 32'(issue_cnt[RING_LOG-1:0]);   // Ring index
        rd_req_hdr.mdata    = 12'(issue_cnt[SLOT_LOG-1:0]);               // Slot tag
    end

    // ------------------------------------------------------------
    // Reorder slots, drained strictly in issue order
    // ------------------------------------------------------------
    assign head         = consumed_count[SLOT_LOG-1:0];
    assign rsp_slot     = rsp_tag[SLOT_LOG-1:0];
    assign rx_fifo_rdy  = slot_full[head];
    assign rx_fifo_data = slot_data[head];
    assign pop          = rx_fifo_enable && rx_fifo_rdy;

    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            slot_full      <= '0;
            issue_cnt      <= '0;
            consumed_count <= '0;
        end
        else
        begin
            if (pop)
            begin
                slot_full[head] <= 1'b0;
                consumed_count  <= consumed_count + 1'b1;
            end
            // A slot is refilled only after its pop, so no clash with head
            if (rsp_valid)
                slot_full[rsp_slot] <= 1'b1;
            if (rd_req_valid)
                issue_cnt <= issue_cnt + 1'b1;
        end
    end

    // Line storage
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (rsp_valid)
            slot_data[rsp_slot] <= rsp_data;
    end

endmodule

// File: logic/frame_writer.sv
// Client words to ring line writes

module frame_writer
#(
    parameter int DATA_WIDTH = 64,
    parameter int RING_LOG   = 4
)
(
    input  logic                    vl_clk_LPdomain_32ui,
    input  logic                    rst_n,

    input  logic                    enable,
    input  logic [31:0]             write_base,

    // Client transmit side
    input  logic [DATA_WIDTH-1:0]   tx_fifo_data,
    input  logic                    tx_fifo_enable,
    output logic                    tx_fifo_rdy,

    // Request toward the write arbiter
    output logic                    req_valid,
    output qa_drv_pkg::t_tx_hdr     req_hdr,
    output logic [DATA_WIDTH-1:0]   req_data,
    input  logic                    grant
);

    logic [RING_LOG-1:0] wr_idx;        // Next ring line to write
    logic                req_full;      // One-word request register occupied

    assign tx_fifo_rdy = enable && !req_full;
    assign req_valid   = req_full;

    always_comb
    begin
        req_hdr          = '0;
        req_hdr.req_type = qa_drv_pkg::REQ_WR_LINE;
        req_hdr.addr     = write_base + 32'(wr_idx);
        req_hdr.mdata    = 12'(wr_idx);     // Tag is the ring index
    end

    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            req_full <= 1'b0;
            wr_idx   <= '0;
        end
        else if (tx_fifo_enable && tx_fifo_rdy)
            req_full <= 1'b1;               // Push only when empty, never with grant
        else if (grant)
        begin
            req_full <= 1'b0;
            wr_idx   <= wr_idx + 1'b1;      // Wraps modulo ring size
        end
    end

    // Payload register
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (tx_fifo_enable && tx_fifo_rdy)
            req_data <= tx_fifo_data;
    end

endmodule

// File: logic/qa_driver.sv
// Host link driver top level

module qa_driver
#(
    parameter int DATA_WIDTH = 64,
    parameter int RING_LOG   = 4,
    parameter int SLOT_LOG   = 2
)
(
    input  logic                    vl_clk_LPdomain_32ui,
    input  logic                    rst_n,

    // ------------------------------------------------------------
    // Host side
    // ------------------------------------------------------------
    input  qa_drv_pkg::t_rx_hdr     rx0_hdr,
    input  logic [DATA_WIDTH-1:0]   rx0_data,
    input  logic                    rx0_rdvalid,    // Read response
    input  logic                    rx0_cfgvalid,   // Config write
    input  logic                    tx0_almostfull,
    input  logic                    tx1_almostfull,
    input  logic                    lp_initdone,

    output qa_drv_pkg::t_tx_hdr     tx0_hdr,
    output logic                    tx0_rdvalid,
    output qa_drv_pkg::t_tx_hdr     tx1_hdr,
    output logic [DATA_WIDTH-1:0]   tx1_data,
    output logic                    tx1_wrvalid,

    // ------------------------------------------------------------
    // Client side
    // ------------------------------------------------------------
    output logic [DATA_WIDTH-1:0]   rx_fifo_data,
    output logic                    rx_fifo_rdy,
    input  logic                    rx_fifo_enable,
    input  logic [DATA_WIDTH-1:0]   tx_fifo_data,
    output logic                    tx_fifo_rdy,
    input  logic                    tx_fifo_enable
);

    logic [31:0]            read_base, write_base, status_addr;
    logic                   enable;
    logic [RING_LOG:0]      consumed_count;

    qa_drv_pkg::t_tx_hdr    rd_req_hdr;     // Unregistered channel 0 request
    logic                   rd_req_valid;
    qa_drv_pkg::t_tx_hdr    fw_hdr, sw_hdr, wr_hdr;
    logic [DATA_WIDTH-1:0]  fw_data, sw_data, wr_data;
    logic                   fw_valid, sw_valid, wr_valid;
    logic                   fw_grant, sw_grant;

    // Every host-bound signal leaves from a flop
    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            tx0_rdvalid <= 1'b0;
            tx1_wrvalid <= 1'b0;
        end
        else
        begin
            tx0_rdvalid <= rd_req_valid;
            tx1_wrvalid <= wr_valid;
        end
    end

    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        tx0_hdr  <= rd_req_hdr;
        tx1_hdr  <= wr_hdr;
        tx1_data <= wr_data;
    end

    qa_drv_csr csr_inst
    (
        .vl_clk_LPdomain_32ui, .rst_n,
        .cfg_valid(rx0_cfgvalid), .cfg_index(rx0_hdr.mdata), .cfg_value(rx0_data[31:0]),
        .read_base, .write_base, .status_addr, .enable
    );

    frame_reader #(.DATA_WIDTH(DATA_WIDTH), .RING_LOG(RING_LOG), .SLOT_LOG(SLOT_LOG))
    reader_inst
    (
        .vl_clk_LPdomain_32ui, .rst_n, .enable, .lp_initdone, .read_base,
        .almostfull(tx0_almostfull), .rd_req_hdr, .rd_req_valid,
        .rsp_valid(rx0_rdvalid), .rsp_tag(rx0_hdr.mdata), .rsp_data(rx0_data),
        .rx_fifo_data, .rx_fifo_rdy, .rx_fifo_enable, .consumed_count
    );

    frame_writer #(.DATA_WIDTH(DATA_WIDTH), .RING_LOG(RING_LOG)) writer_inst
    (
        .vl_clk_LPdomain_32ui, .rst_n, .enable, .write_base,
        .tx_fifo_data, .tx_fifo_enable, .tx_fifo_rdy,
        .req_valid(fw_valid), .req_hdr(fw_hdr), .req_data(fw_data), .grant(fw_grant)
    );

    qa_drv_status_writer #(.DATA_WIDTH(DATA_WIDTH), .RING_LOG(RING_LOG)) status_inst
    (
        .vl_clk_LPdomain_32ui, .rst_n, .enable, .status_addr, .consumed_count,
        .req_valid(sw_valid), .req_hdr(sw_hdr), .req_data(sw_data), .grant(sw_grant)
    );

    cci_write_arbiter #(.DATA_WIDTH(DATA_WIDTH)) wr_arb_inst
    (
        .vl_clk_LPdomain_32ui, .rst_n, .almostfull(tx1_almostfull),
        .req_valid_a(fw_valid), .req_hdr_a(fw_hdr), .req_data_a(fw_data),
        .req_valid_b(sw_valid), .req_hdr_b(sw_hdr), .req_data_b(sw_data),
        .grant_a(fw_grant), .grant_b(sw_grant), .wr_hdr, .wr_data, .wr_valid
    );

endmodule

// File: logic/qa_drv_csr.sv
// Driver configuration registers

module qa_drv_csr
(
    input  logic        vl_clk_LPdomain_32ui,
    input  logic        rst_n,

    // Config writes from rx channel 0
    input  logic        cfg_valid,
    input  logic [11:0] cfg_index,
    input  logic [31:0] cfg_value,

    // Decoded state
    output logic [31:0] read_base,
    output logic [31:0] write_base,
    output logic [31:0] status_addr,
    output logic        enable
);

    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
        begin
            read_base   <= '0;
            write_base  <= '0;
            status_addr <= '0;
            enable      <= 1'b0;   // Both data paths idle after reset
        end
        else if (cfg_valid)
        begin
            // Unknown indices fall through and change nothing
            case (cfg_index)
                qa_drv_pkg::CSR_READ_BASE:   read_base   <= cfg_value;
                qa_drv_pkg::CSR_WRITE_BASE:  write_base  <= cfg_value;
                qa_drv_pkg::CSR_STATUS_ADDR: status_addr <= cfg_value;
                qa_drv_pkg::CSR_ENABLE:      enable      <= cfg_value[0];
                default:
                begin
                end
            endcase
        end
    end

endmodule

// File: logic/qa_drv_pkg.sv
// Host link driver shared definitions

package qa_drv_pkg;

    // ------------------------------------------------------------
    // Request and response headers
    // ------------------------------------------------------------

    // Request header on tx channels 0 and 1 (61 bits)
    typedef struct packed {
        logic [12:0] rsvd;      // Always zero
        logic [3:0]  req_type;  // REQ_RD_LINE or REQ_WR_LINE
        logic [31:0] addr;      // Line address
        logic [11:0] mdata;     // Request tag
    } t_tx_hdr;

    // Response header on rx channel 0 (18 bits)
    typedef struct packed {
        logic [1:0]  rsvd;
        logic [3:0]  rsp_type;  // Response code
        logic [11:0] mdata;     // Tag echoed from the request
    } t_rx_hdr;

    // ------------------------------------------------------------
    // Request and response codes
    // ------------------------------------------------------------
    localparam logic [3:0] REQ_WR_LINE = 4'h2;  // Line write request
    localparam logic [3:0] REQ_RD_LINE = 4'h4;  // Line read request
    localparam logic [3:0] RSP_RD_LINE = 4'h4;  // Read data response

    // ------------------------------------------------------------
    // CSR indices, carried in mdata of a config write
    // ------------------------------------------------------------
    localparam logic [11:0] CSR_READ_BASE   = 12'h0a0;  // Read ring line address
    localparam logic [11:0] CSR_WRITE_BASE  = 12'h0a4;  // Write ring line address
    localparam logic [11:0] CSR_STATUS_ADDR = 12'h0a8;  // Status line address
    localparam logic [11:0] CSR_ENABLE      = 12'h0ac;  // Bit 0 starts both paths

endpackage

// File: logic/qa_drv_status_writer.sv
// Consumed-line status writer

module qa_drv_status_writer
#(
    parameter int DATA_WIDTH = 64,
    parameter int RING_LOG   = 4
)
(
    input  logic                    vl_clk_LPdomain_32ui,
    input  logic                    rst_n,

    input  logic                    enable,
    input  logic [31:0]             status_addr,
    input  logic [RING_LOG:0]       consumed_count,

    output logic                    req_valid,
    output qa_drv_pkg::t_tx_hdr     req_hdr,
    output logic [DATA_WIDTH-1:0]   req_data,
    input  logic                    grant
);

    logic [RING_LOG:0] last_posted;     // Count carried by the last granted write

    assign req_valid = enable && (consumed_count != last_posted);
    assign req_data  = DATA_WIDTH'(consumed_count);     // Always the live count

    always_comb
    begin
        req_hdr          = '0;
        req_hdr.req_type = qa_drv_pkg::REQ_WR_LINE;
        req_hdr.addr     = status_addr;
        req_hdr.mdata    = 12'h000;
    end

    always_ff @(posedge vl_clk_LPdomain_32ui)
    begin
        if (!rst_n)
            last_posted <= '0;
        else if (grant)
            last_posted <= consumed_count;  // Same value as the data sent
    end

endmodule

// File: sim.f
logic/qa_drv_pkg.sv
logic/qa_drv_csr.sv
logic/frame_reader.sv
logic/frame_writer.sv
logic/qa_drv_status_writer.sv
logic/cci_write_arbiter.sv
logic/qa_driver.sv
dv/qa_driver_chk.sv
dv/qa_driver_tb.sv
